/* build.f */
common/img_pkg.sv
bank/pixel_bank.sv
bank/bank_router.sv
bank/bank_reader.sv
rtl/img_ctrl.sv
rtl/img_core.sv
verif/img_core_assert.sv
verif/img_checker.sv
verif/tb_img_core.sv

/* Makefile */
TOP := tb_img_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o V$(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_img_core.sv */
module tb_img_core import img_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // longest idle stretch before a load pixel
    localparam int GAP_MAX = 3;
    // two loads at worst pace, displays and short ops, then slack
    localparam int LIMIT   = 2 * IMG_PIX * (GAP_MAX + 1) + 12 * 4 * IMG_C + 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    op_valid;
    logic [3:0]              op_mode;
    logic                    in_valid;
    pix_t                    in_data;
    logic                    op_ready;
    logic                    in_ready;
    logic                    out_valid;
    logic signed [OUT_W-1:0] out_data;
    int                      err_count;
    int                      cycles;
    int                      assert_fails;

    // --------------------
    // reference model
    // --------------------
    pix_t ref_img [IMG_C][IMG_H][IMG_W];
    int   ref_ox;
    int   ref_oy;
    int   ref_depth;

    img_core #(
        .BANK_COUNT (4)
    ) dut_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_op_valid  (op_valid),
        .i_op_mode   (op_mode),
        .i_in_valid  (in_valid),
        .i_in_data   (in_data),
        .o_op_ready  (op_ready),
        .o_in_ready  (in_ready),
        .o_out_valid (out_valid),
        .o_out_data  (out_data)
    );

    img_checker chk_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_out_valid (out_valid),
        .i_out_data  (out_data),
        .o_err_count (err_count)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected pixel at window position pos of channel c
    // pos order: (ox,oy) (ox+1,oy) (ox,oy+1) (ox+1,oy+1)
    function automatic logic signed [OUT_W-1:0] window_pixel(input int c, input int pos);
        int x;
        int y;
        x = ref_ox + pos % 2;
        y = ref_oy + pos / 2;
        return OUT_W'(ref_img[c][y][x]);
    endfunction

    task automatic expect_display();
        for (int c = 0; c < ref_depth; c++) begin
            for (int pos = 0; pos < 4; pos++) begin
                chk_i.push_expected(window_pixel(c, pos));
            end
        end
    endtask

    // clamp rules for origin and depth, anything else is a no-op
    task automatic model_op(input logic [3:0] code);
        case (code)
            4'(OP_ORG_R):   if (ref_ox < ORG_MAX) ref_ox++;
            4'(OP_ORG_L):   if (ref_ox > 0) ref_ox--;
            4'(OP_ORG_U):   if (ref_oy > 0) ref_oy--;
            4'(OP_ORG_D):   if (ref_oy < ORG_MAX) ref_oy++;
            4'(OP_SCALE_D): if (ref_depth > 8) ref_depth = ref_depth / 2;
            4'(OP_SCALE_U): if (ref_depth < IMG_C) ref_depth = ref_depth * 2;
            default: ;
        endcase
    endtask

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic wait_ready();
        do @(negedge clk); while (op_ready !== 1'b1);
    endtask

    // one-cycle op strobe, returns right after the accepting edge
    task automatic send_op(input logic [3:0] code);
        @(posedge clk);
        op_valid <= 1'b1;
        op_mode  <= code;
        @(posedge clk);
        op_valid <= 1'b0;
    endtask

    task automatic run_op(input logic [3:0] code);
        send_op(code);
        model_op(code);
        wait_ready();
    endtask

    task automatic display_window();
        expect_display();
        send_op(4'(OP_DISPLAY));
        wait_ready();
        // whole stream is out by the ready pulse
        chk_i.check_drained();
    endtask

    // raster order, random idle gaps in in_valid
    task automatic load_image();
        int   gap;
        pix_t pix;
        send_op(4'(OP_LOAD));
        for (int i = 0; i < IMG_PIX; i++) begin
            gap = ($urandom % 4 == 0) ? int'($urandom_range(GAP_MAX, 1)) : 0;
            repeat (gap) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            pix = pix_t'($urandom);
            ref_img[i / (IMG_W * IMG_H)][(i / IMG_W) % IMG_H][i % IMG_W] = pix;
            in_valid <= 1'b1;
            in_data  <= pix;
            // core must be asking for input when the pixel is taken
            @(negedge clk);
            chk_i.check_bit("o_in_ready", in_ready, 1'b1);
            @(posedge clk);
        end
        in_valid <= 1'b0;
        wait_ready();
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        void'($urandom(24));
        ref_ox    = 0;
        ref_oy    = 0;
        ref_depth = IMG_C;
        rst_n    <= 1'b0;
        op_valid <= 1'b0;
        op_mode  <= '0;
        in_valid <= 1'b0;
        in_data  <= '0;

        chk_i.begin_test("startup");
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
            chk_i.check_bit("o_in_ready", in_ready, 1'b0);
            chk_i.check_bit("o_out_valid", out_valid, 1'b0);
        end while (op_ready !== 1'b1);
        // single pulse only
        @(negedge clk);
        chk_i.check_bit("o_op_ready", op_ready, 1'b0);
        chk_i.end_test();

        chk_i.begin_test("load_display");
        load_image();
        display_window();
        chk_i.end_test();

        chk_i.begin_test("origin_clamp");
        repeat (7) run_op(4'(OP_ORG_R));
        repeat (7) run_op(4'(OP_ORG_D));
        display_window();
        repeat (2) run_op(4'(OP_ORG_L));
        run_op(4'(OP_ORG_U));
        display_window();
        repeat (8) run_op(4'(OP_ORG_L));
        repeat (8) run_op(4'(OP_ORG_U));
        display_window();
        // leave an off-corner origin for the later tests
        repeat (2) run_op(4'(OP_ORG_R));
        run_op(4'(OP_ORG_D));
        display_window();
        chk_i.end_test();

        chk_i.begin_test("depth_clamp");
        repeat (3) run_op(4'(OP_SCALE_D));
        display_window();
        repeat (4) run_op(4'(OP_SCALE_U));
        display_window();
        chk_i.end_test();

        chk_i.begin_test("undefined_ops");
        for (int code = 8; code < 16; code++) begin
            run_op(4'(code));
        end
        display_window();
        chk_i.end_test();

        chk_i.begin_test("reload");
        run_op(4'(OP_ORG_R));
        run_op(4'(OP_SCALE_D));
        load_image();
        display_window();
        chk_i.end_test();

        assert_fails = dut_i.assert_i.fail_cnt;
        chk_i.report_counts(assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        chk_i.note_timeout(cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* verif/img_checker.sv */
module img_checker import img_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_out_valid,
    input  logic signed [OUT_W-1:0] i_out_data,
    output int                      o_err_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // expected display values, filled by the testbench top
    logic signed [OUT_W-1:0] exp_q [$];
    logic signed [OUT_W-1:0] exp_val;
    int                      err_count = 0;
    int                      test_err_start = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      out_count = 0;
    string                   test_name = "none";

    assign o_err_count = err_count;

    // --------------------
    // test bookkeeping
    // --------------------
    task automatic push_expected(input logic signed [OUT_W-1:0] v);
        exp_q.push_back(v);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = err_count;
        out_count      = 0;
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, sig, got, exp);
        end
    endtask

    // values still queued were never produced
    task automatic check_drained();
        if (exp_q.size() != 0) begin
            err_count++;
            $display("test %s is missing %0d display outputs", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic end_test();
        check_drained();
        tests_run++;
        if (err_count != test_err_start) begin
            tests_failed++;
            $display("test %-14s FAIL  %0d outputs, %0d errors", test_name, out_count,
                     err_count - test_err_start);
        end else begin
            $display("test %-14s PASS  %0d outputs", test_name, out_count);
        end
    endtask

    task automatic note_timeout(input int cycles);
        err_count++;
        $display("o_op_ready never arrived in test %s, run stopped after %0d cycles",
                 test_name, cycles);
    endtask

    task automatic report_counts(input int assert_fails);
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count, assert_fails);
    endtask

    // --------------------
    // output compare
    // --------------------
    // sampled on the falling edge, away from register updates
    always @(negedge i_clk) begin
        if (i_rst_n && i_out_valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("extra output %0d at %0t in test %s, nothing was expected",
                         i_out_data, $time, test_name);
            end else begin
                exp_val = exp_q.pop_front();
                if (i_out_data !== exp_val) begin
                    err_count++;
                    $display("[ERROR] t=%0t o_out_data got %0d expected %0d", $time,
                             i_out_data, exp_val);
                end
            end
        end
    end

endmodule

/* verif/img_core_assert.sv */
module img_core_assert import img_pkg::*; (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input logic                    i_op_ready,
    input logic                    i_in_ready,
    input logic                    i_out_valid,
    input logic signed [OUT_W-1:0] i_out_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // failure count, read back by the testbench top
    int fail_cnt = 0;

    // ready is a one-cycle pulse
    a_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_op_ready |=> !i_op_ready)
        else begin
            fail_cnt++;
            $error("o_op_ready high two cycles in a row");
        end

    // load and display never overlap
    a_in_out_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_in_ready && i_out_valid))
        else begin
            fail_cnt++;
            $error("o_in_ready and o_out_valid high together");
        end

    // idle output data held at zero
    a_data_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_out_valid |-> (i_out_data == '0))
        else begin
            fail_cnt++;
            $error("o_out_data nonzero while o_out_valid is low");
        end

    // quiet outputs on the first edge after reset release
    a_reset_quiet: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !(i_op_ready || i_in_ready || i_out_valid))
        else begin
            fail_cnt++;
            $error("output high right after reset release");
        end

endmodule

bind img_core img_core_assert assert_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_op_ready  (o_op_ready),
    .i_in_ready  (o_in_ready),
    .i_out_valid (o_out_valid),
    .i_out_data  (o_out_data)
);

/* rtl/img_core.sv */
module img_core import img_pkg::*; #(
    parameter int BANK_COUNT = 4
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_op_valid,
    input  logic [3:0]              i_op_mode,
    input  logic                    i_in_valid,
    input  pix_t                    i_in_data,
    output logic                    o_op_ready,
    output logic                    o_in_ready,
    output logic                    o_out_valid,
    output logic signed [OUT_W-1:0] o_out_data
);

    // pixels split evenly over the banks
    localparam int BANK_DEPTH = IMG_PIX / BANK_COUNT;
    localparam int ADDR_W     = $clog2(BANK_DEPTH);
    localparam int SEL_W      = $clog2(BANK_COUNT);

    // --------------------
    // controller to router
    // --------------------
    logic   wr_en;
    logic   rd_en;
    coord_t pix_x;
    coord_t pix_y;
    chan_t  pix_c;
    pix_t   wr_data;

    // router to banks and reader
    logic [BANK_COUNT-1:0] bank_we;
    logic [ADDR_W-1:0]     bank_addr;
    pix_t                  bank_wdata;
    logic                  rd_strobe;
    logic [SEL_W-1:0]      rd_sel;

    // bank read data, one lane per bank
    pix_t bank_rdata [BANK_COUNT];

    img_ctrl ctrl_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op_valid (i_op_valid),
        .i_op_mode  (op_t'(i_op_mode)),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_op_ready (o_op_ready),
        .o_in_ready (o_in_ready),
        .o_wr_en    (wr_en),
        .o_rd_en    (rd_en),
        .o_x        (pix_x),
        .o_y        (pix_y),
        .o_c        (pix_c),
        .o_wr_data  (wr_data)
    );

    bank_router #(
        .BANK_COUNT (BANK_COUNT),
        .BANK_DEPTH (BANK_DEPTH)
    ) router_i (
        .i_wr_en      (wr_en),
        .i_rd_en      (rd_en),
        .i_x          (pix_x),
        .i_y          (pix_y),
        .i_c          (pix_c),
        .i_wr_data    (wr_data),
        .o_bank_we    (bank_we),
        .o_bank_addr  (bank_addr),
        .o_bank_wdata (bank_wdata),
        .o_rd_en      (rd_strobe),
        .o_rd_sel     (rd_sel)
    );

    // --------------------
    // pixel banks
    // --------------------
    for (genvar gi = 0; gi < BANK_COUNT; gi++) begin : g_bank
        pixel_bank #(
            .DEPTH (BANK_DEPTH)
        ) bank_i (
            .i_clk   (i_clk),
            .i_we    (bank_we[gi]),
            .i_addr  (bank_addr),
            .i_wdata (bank_wdata),
            .o_rdata (bank_rdata[gi])
        );
    end

    bank_reader #(
        .BANK_COUNT (BANK_COUNT)
    ) reader_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rd_en      (rd_strobe),
        .i_rd_sel     (rd_sel),
        .i_bank_rdata (bank_rdata),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data)
    );

endmodule

/* rtl/img_ctrl.sv */
module img_ctrl import img_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_op_valid,
    input  op_t    i_op_mode,
    input  logic   i_in_valid,
    input  pix_t   i_in_data,
    output logic   o_op_ready,
    output logic   o_in_ready,
    output logic   o_wr_en,
    output logic   o_rd_en,
    output coord_t o_x,
    output coord_t o_y,
    output chan_t  o_c,
    output pix_t   o_wr_data
);

    localparam int CNT_W = $clog2(IMG_PIX);

    // boot states give the startup ready pulse on the third edge
    typedef enum logic [2:0] {
        S_BOOT, S_BOOT2, S_RDY, S_IDLE, S_LOAD, S_DISP, S_DRAIN
    } state_t;

    state_t           state;
    coord_t           org_x;
    coord_t           org_y;
    depth_t           depth;
    // load: raster index; display: {chan, pos}; drain: wait cycles
    logic [CNT_W-1:0] cnt;
    logic             load_last;
    logic             disp_last;

    assign load_last = (cnt == CNT_W'(IMG_PIX - 1));
    // pos 3 of the last displayed channel
    assign disp_last = (cnt[1:0] == 2'd3) &&
                       ({1'b0, cnt[6:2]} == depth_value(depth) - 6'd1);

    // --------------------
    // strobes and address
    // --------------------
    assign o_op_ready = (state == S_RDY);
    assign o_in_ready = (state == S_LOAD);
    assign o_wr_en    = (state == S_LOAD) && i_in_valid;
    assign o_rd_en    = (state == S_DISP);
    // pixel goes straight to the banks
    assign o_wr_data  = i_in_data;

    always_comb begin
        if (state == S_LOAD) begin
            o_x = cnt[2:0];
            o_y = cnt[5:3];
            o_c = cnt[10:6];
        end else begin
            // window corner plus 2x2 offset
            o_x = org_x + {2'b00, cnt[0]};
            o_y = org_y + {2'b00, cnt[1]};
            o_c = cnt[6:2];
        end
    end

    // --------------------
    // main FSM
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= S_BOOT;
            org_x <= '0;
            org_y <= '0;
            depth <= DEPTH_32;
            cnt   <= '0;
        end else begin
            case (state)
                S_BOOT:  state <= S_BOOT2;
                S_BOOT2: state <= S_RDY;
                S_RDY:   state <= S_IDLE;
                S_IDLE: begin
                    if (i_op_valid) begin
                        cnt   <= '0;
                        // short ops and undefined codes just pulse ready
                        state <= S_RDY;
                        case (i_op_mode)
                            OP_LOAD:    state <= S_LOAD;
                            OP_DISPLAY: state <= S_DISP;
                            // origin moves clamp at 0 and ORG_MAX
                            OP_ORG_R: begin
                                if (org_x < coord_t'(ORG_MAX)) org_x <= org_x + 3'd1;
                            end
                            OP_ORG_L: begin
                                if (org_x != '0) org_x <= org_x - 3'd1;
                            end
                            OP_ORG_U: begin
                                if (org_y != '0) org_y <= org_y - 3'd1;
                            end
                            OP_ORG_D: begin
                                if (org_y < coord_t'(ORG_MAX)) org_y <= org_y + 3'd1;
                            end
                            // depth steps 32 -> 16 -> 8, held at the ends
                            OP_SCALE_D: begin
                                if (depth == DEPTH_32) depth <= DEPTH_16;
                                else if (depth == DEPTH_16) depth <= DEPTH_8;
                            end
                            OP_SCALE_U: begin
                                if (depth == DEPTH_8) depth <= DEPTH_16;
                                else if (depth == DEPTH_16) depth <= DEPTH_32;
                            end
                            default: ;
                        endcase
                    end
                end
                S_LOAD: begin
                    // gaps in i_in_valid stall the count
                    if (i_in_valid) begin
                        cnt <= cnt + 1'b1;
                        if (load_last) state <= S_RDY;
                    end
                end
                S_DISP: begin
                    if (disp_last) begin
                        cnt   <= '0;
                        state <= S_DRAIN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    // two reads still in bank and reader
                    cnt <= cnt + 1'b1;
                    if (cnt[0]) state <= S_RDY;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* bank/bank_reader.sv */
module bank_reader import img_pkg::*; #(
    parameter int BANK_COUNT = 4
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_rd_en,
    input  logic [$clog2(BANK_COUNT)-1:0] i_rd_sel,
    input  pix_t                          i_bank_rdata [BANK_COUNT],
    output logic                          o_out_valid,
    output logic signed [OUT_W-1:0]       o_out_data
);

    localparam int SEL_W = $clog2(BANK_COUNT);

    logic             rd_en_q;
    logic [SEL_W-1:0] rd_sel_q;
    pix_t             sel_pix;

    // --------------------
    // align with bank read
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_en_q  <= 1'b0;
            rd_sel_q <= '0;
        end else begin
            rd_en_q  <= i_rd_en;
            rd_sel_q <= i_rd_sel;
        end
    end

    assign sel_pix = i_bank_rdata[rd_sel_q];

    // output stage, data held at zero between values
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_out_data  <= '0;
        end else begin
            o_out_valid <= rd_en_q;
            // zero-extended pixel
            o_out_data  <= rd_en_q ? $signed({{(OUT_W - PIX_W){1'b0}}, sel_pix}) : '0;
        end
    end

endmodule

/* bank/bank_router.sv */
module bank_router import img_pkg::*; #(
    parameter int BANK_COUNT = 4,
    parameter int BANK_DEPTH = 512
) (
    input  logic                          i_wr_en,
    input  logic                          i_rd_en,
    input  coord_t                        i_x,
    input  coord_t                        i_y,
    input  chan_t                         i_c,
    input  pix_t                          i_wr_data,
    output logic [BANK_COUNT-1:0]         o_bank_we,
    output logic [$clog2(BANK_DEPTH)-1:0] o_bank_addr,
    output pix_t                          o_bank_wdata,
    output logic                          o_rd_en,
    output logic [$clog2(BANK_COUNT)-1:0] o_rd_sel
);

    localparam int SEL_W  = $clog2(BANK_COUNT);
    localparam int ADDR_W = $clog2(BANK_DEPTH);
    // one channel plane inside a bank
    localparam int PLANE  = IMG_W * IMG_H;

    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] offset;

    // --------------------
    // channel interleave
    // --------------------
    always_comb begin
        // low channel bits pick the bank
        sel    = i_c[SEL_W-1:0];
        // upper channel bits pick the plane, then y and x
        offset = ADDR_W'(int'(i_c >> SEL_W) * PLANE + int'(i_y) * IMG_W + int'(i_x));
    end

    always_comb begin
        o_bank_we = '0;
        if (i_wr_en) begin
            o_bank_we[sel] = 1'b1;
        end
    end

    // address and data shared by all banks
    assign o_bank_addr  = offset;
    assign o_bank_wdata = i_wr_data;
    // reader needs the bank index along with the strobe
    assign o_rd_en      = i_rd_en;
    assign o_rd_sel     = sel;

endmodule

/* bank/pixel_bank.sv */
module pixel_bank import img_pkg::*; #(
    parameter int DEPTH = 512
) (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  pix_t                     i_wdata,
    output pix_t                     o_rdata
);

    // storage
    pix_t mem [DEPTH];

    // single port: write wins, else registered read
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end else begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

/* common/img_pkg.sv */
package img_pkg;

    // --------------------
    // image geometry
    // --------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_C   = 32;
    // raster order is x fastest, then y, then channel
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;

    // datapath widths
    localparam int PIX_W   = 8;
    localparam int OUT_W   = 14;

    // 2x2 window must stay inside the 8x8 plane
    localparam int ORG_MAX = 6;

    // --------------------
    // basic types
    // --------------------
    typedef logic [2:0]       coord_t;
    typedef logic [4:0]       chan_t;
    typedef logic [PIX_W-1:0] pix_t;

    // opcodes 8..15 fall outside the enum and count as undefined
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,
        OP_SCALE_U = 4'd6,
        OP_DISPLAY = 4'd7
    } op_t;

    // displayed depth code
    typedef enum logic [1:0] {
        DEPTH_8  = 2'd0,
        DEPTH_16 = 2'd1,
        DEPTH_32 = 2'd2
    } depth_t;

    // channel count for a depth code
    function automatic logic [5:0] depth_value(input depth_t d);
        case (d)
            DEPTH_8:  depth_value = 6'd8;
            DEPTH_16: depth_value = 6'd16;
            default:  depth_value = 6'(IMG_C);
        endcase
    endfunction

endpackage
